// ==== tests/sd2snes_golden.txt ====
// op addr data expected, one operation per line, all hex
// op 1 MCU read, 2 MCU write, 3 SNES read, 4 MCU read during ROM cycles, 5 rom_mask, 0 end
1 012345 00 A2
1 3C5A76 00 11
2 00A0F0 5C 00
1 00A0F0 00 5C
1 00A0F1 00 78
2 00A0F1 E3 00
1 00A0F1 00 E3
1 00A0F0 00 5C
5 0FFFFF 00 00
3 8ABCDE 00 54
3 F0A0F1 00 E3
5 FFFFFF 00 00
3 7FFFFE 00 81
4 012345 00 A2
4 00A0F0 00 5C
2 000201 3D 00
1 000201 00 3D
1 000200 00 01
0 000000 00 00

// ==== compile.f ====
common/snes_pkg.sv
snes_bus/snes_bus_sync.sv
rom/rom_arbiter.sv
rom/rom_port_mux.sv
logic/sd2snes_main.sv
tests/sd2snes_main_asserts.sv
tests/tb_sd2snes_main.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sd2snes_main -Mdir obj_dir -f compile.f

./obj_dir/Vtb_sd2snes_main | tee sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported a failure"
  exit 1
fi

// ==== tests/tb_sd2snes_main.sv ====
`timescale 1ns/1ns

module tb_sd2snes_main;

  logic        CLK2 = 1'b0;
  logic        SNES_reset_strobe;
  logic [23:0] snes_addr_raw;
  logic [7:0]  snes_data_raw;
  logic        snes_read_raw;
  logic        snes_write_raw;
  logic        snes_romsel_raw;
  logic        snes_cpu_clk_raw = 1'b0;
  logic [7:0]  snes_data_out;
  logic        snes_databus_dir;
  logic [7:0]  snes_data_in;
  logic        rd_start;
  logic        rd_end;
  logic        wr_end;
  logic        snes_dead;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_dout;
  logic [23:0] rom_mask;
  logic        mcu_rdy;
  logic [7:0]  mcu_din;
  logic [15:0] rom_data_in = 16'h0000;
  logic [22:0] rom_addr;
  logic        rom_bhe;
  logic        rom_ble;
  logic        rom_we;
  logic [15:0] rom_data_out;
  logic        rom_data_oe;

  logic [31:0] golden [0:255];               // op, addr, data, expected per line
  logic [15:0] psram_written [logic [22:0]]; // words changed by MCU writes
  logic [15:0] merged_word;
  logic [23:0] cur_mask;
  logic        cpu_run;
  logic [3:0]  cpu_phase = 4'd0;
  int          fall_count = 0;

  sd2snes_main i_sd2snes_main (.*);

  always #50 CLK2 = ~CLK2;

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM model
  ////////////////////////////////////////////////////////////////////////////

  // power-up contents, every address bit matters
  function automatic logic [15:0] fill_word(input logic [22:0] waddr);
    return waddr[15:0] ^ {waddr[22:16], 9'h000};
  endfunction

  function automatic logic [15:0] stored_word(input logic [22:0] waddr);
    if (psram_written.exists(waddr)) begin
      return psram_written[waddr];
    end
    return fill_word(waddr);
  endfunction

  function automatic logic [7:0] byte_at(input logic [23:0] addr);
    logic [15:0] w;
    w = stored_word(addr[23:1]);
    return addr[0] ? w[7:0] : w[15:8];  // odd byte on the low lane
  endfunction

  always @(posedge CLK2) begin
    if (rom_we === 1'b0 && !$isunknown(rom_addr)) begin
      merged_word = stored_word(rom_addr);
      if (rom_bhe === 1'b0) merged_word[15:8] = rom_data_out[15:8];
      if (rom_ble === 1'b0) merged_word[7:0] = rom_data_out[7:0];
      psram_written[rom_addr] = merged_word;
    end
    if ($isunknown(rom_addr)) begin
      rom_data_in <= 16'h0000;  // address pipe not filled yet
    end else begin
      rom_data_in <= stored_word(rom_addr);  // one cycle read latency
    end
  end

  // SNES CPU clock, 6 high 6 low
  always @(posedge CLK2) begin
    if (cpu_run) begin
      snes_cpu_clk_raw <= (cpu_phase < 4'd6);
      cpu_phase        <= (cpu_phase == 4'd11) ? 4'd0 : cpu_phase + 4'd1;
      if (cpu_phase == 4'd6) fall_count <= fall_count + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks and waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("ERROR %s", what);
    $display("test failed");
    $fatal(1, "%s", what);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
      $display("test failed");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  task automatic wait_rdy(input logic level, input int limit);
    int n;
    n = 0;
    @(negedge CLK2);
    while (mcu_rdy !== level) begin
      if (n >= limit) begin
        report_failure("timeout waiting for mcu_rdy");
      end else begin
        n++;
        @(negedge CLK2);
      end
    end
  endtask

  task automatic issue_request(input logic is_write, input logic [23:0] addr,
                               input logic [7:0] data);
    @(posedge CLK2);
    mcu_addr <= addr;
    mcu_dout <= data;  // held until the next request
    if (is_write) mcu_wrq <= 1'b1;
    else mcu_rrq <= 1'b1;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
  endtask

  task automatic mcu_read(input logic [23:0] addr, input logic [7:0] expv);
    issue_request(1'b0, addr, 8'h00);
    wait_rdy(1'b0, 4);
    wait_rdy(1'b1, 200);
    check_value("mcu_din", mcu_din, expv);
  endtask

  task automatic mcu_write(input logic [23:0] addr, input logic [7:0] data);
    int n;
    int low_cycles;
    issue_request(1'b1, addr, data);
    wait_rdy(1'b0, 4);
    n = 0;
    low_cycles = 0;
    while (mcu_rdy !== 1'b1) begin
      if (n >= 200) begin
        report_failure("timeout waiting for the MCU write to finish");
      end else begin
        if (rom_we === 1'b0) begin
          low_cycles++;
          check_value("rom_addr", rom_addr, addr[23:1]);
          check_value("rom_bhe", rom_bhe, addr[0]);
          check_value("rom_ble", rom_ble, !addr[0]);
          check_value("rom_data_oe", rom_data_oe, 1);
        end
        n++;
        @(negedge CLK2);
      end
    end
    check_value("rom_we_low_cycles", low_cycles, 8);
    check_value("psram_byte", byte_at(addr), data);
  endtask

  task automatic snes_bus_read(input logic [23:0] addr, input logic [7:0] expv);
    logic [23:0] masked;
    int n;
    masked = addr & cur_mask;
    @(posedge CLK2);
    snes_addr_raw <= addr;
    snes_data_raw <= addr[7:0];  // data bus follows the address low byte
    snes_read_raw <= 1'b0;
    n = 0;
    @(negedge CLK2);
    while (rom_addr !== masked[23:1] || snes_databus_dir !== 1'b1) begin
      if (n >= 20) begin
        report_failure("timeout waiting for the SNES address to settle");
      end else begin
        n++;
        @(negedge CLK2);
      end
    end
    repeat (2) @(negedge CLK2);  // model read latency
    check_value("snes_databus_dir", snes_databus_dir, 1);
    check_value("rom_addr", rom_addr, masked[23:1]);
    check_value("snes_data_out", snes_data_out, expv);
    check_value("snes_data_in", snes_data_in, addr[7:0]);
    @(posedge CLK2);
    snes_read_raw <= 1'b1;
    snes_addr_raw <= 24'h000000;
    snes_data_raw <= 8'h00;
  endtask

  task automatic read_during_rom_cycles(input logic [23:0] addr,
                                        input logic [7:0] expv);
    int n;
    int win;
    int fall_base;
    @(posedge CLK2);
    snes_addr_raw   <= 24'h000000;
    snes_romsel_raw <= 1'b0;  // every CPU cycle hits ROM
    cpu_run         <= 1'b1;
    n = 0;
    @(negedge CLK2);
    while (snes_dead !== 1'b0 || rom_addr !== 23'h000000 || cpu_phase != 4'd1) begin
      if (n >= 100) begin
        report_failure("timeout waiting for the SNES CPU to run");
      end else begin
        n++;
        @(negedge CLK2);
      end
    end
    fall_base = fall_count;  // cpu clock just went high
    issue_request(1'b0, addr, 8'h00);
    wait_rdy(1'b0, 4);
    n = 0;
    win = 0;
    while (mcu_rdy !== 1'b1) begin
      if (n >= 200) begin
        report_failure("timeout waiting for the slot read to finish");
      end else begin
        if (rom_addr === addr[23:1]) begin
          win++;
          check_value("cycle_end_before_window", fall_count > fall_base, 1);
        end
        n++;
        @(negedge CLK2);
      end
    end
    check_value("rom_addr_window_cycles", win, 9);  // 8 ADDR plus END
    check_value("mcu_din", mcu_din, expv);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int idx;
    int gap;
    logic [31:0] op;
    void'($urandom(18217));
    SNES_reset_strobe = 1'b1;
    snes_addr_raw     = 24'h000000;
    snes_data_raw     = 8'h00;
    snes_read_raw     = 1'b1;
    snes_write_raw    = 1'b1;
    snes_romsel_raw   = 1'b1;
    mcu_rrq           = 1'b0;
    mcu_wrq           = 1'b0;
    mcu_addr          = 24'h000000;
    mcu_dout          = 8'h00;
    rom_mask          = 24'hffffff;
    cur_mask          = 24'hffffff;
    cpu_run           = 1'b0;
    for (idx = 0; idx < 256; idx++) begin
      golden[idx] = 32'h0;
    end
    $readmemh("tests/sd2snes_golden.txt", golden);

    repeat (4) @(posedge CLK2);
    SNES_reset_strobe <= 1'b0;
    @(negedge CLK2);
    check_value("mcu_rdy", mcu_rdy, 1);
    check_value("rom_we", rom_we, 1);
    check_value("snes_databus_dir", snes_databus_dir, 0);
    check_value("rd_start", rd_start, 0);
    check_value("rd_end", rd_end, 0);
    check_value("wr_end", wr_end, 0);

    idx = 0;
    while (idx < 64 && golden[idx*4] != 32'h0) begin
      op  = golden[idx*4];
      gap = $urandom % 4;
      repeat (gap) @(posedge CLK2);
      case (op)
        32'h1: mcu_read(golden[idx*4+1][23:0], golden[idx*4+3][7:0]);
        32'h2: mcu_write(golden[idx*4+1][23:0], golden[idx*4+2][7:0]);
        32'h3: snes_bus_read(golden[idx*4+1][23:0], golden[idx*4+3][7:0]);
        32'h4: read_during_rom_cycles(golden[idx*4+1][23:0], golden[idx*4+3][7:0]);
        32'h5: begin
          cur_mask = golden[idx*4+1][23:0];
          @(posedge CLK2);
          rom_mask <= golden[idx*4+1][23:0];
        end
        default: report_failure("unknown operation in the golden file");
      endcase
      idx++;
    end

    if (idx == 0) begin
      $display("golden file holds no operations");
      $display("test failed");
      $fatal(1, "empty golden file");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// ==== tests/sd2snes_main_asserts.sv ====
`timescale 1ns/1ns

module sd2snes_main_asserts (
  input logic                 CLK2,
  input logic                 SNES_reset_strobe,
  input snes_pkg::arb_state_e state,
  input logic                 rom_we,
  input logic                 mcu_rdy
);

  logic in_addr;

  assign in_addr = (state == snes_pkg::arb_mcu_rd_addr) ||
                   (state == snes_pkg::arb_mcu_wr_addr);

  we_only_in_window: assert property (
    @(posedge CLK2) disable iff (SNES_reset_strobe)
    (state == snes_pkg::arb_idle) |-> rom_we
  ) else $error("rom_we low while the arbiter is idle");

  rdy_low_when_busy: assert property (
    @(posedge CLK2) disable iff (SNES_reset_strobe)
    (state != snes_pkg::arb_idle) |-> !mcu_rdy
  ) else $error("mcu_rdy high during an MCU access");

  // leaving ADDR means exactly 8 cycles were spent there
  addr_window_len: assert property (
    @(posedge CLK2) disable iff (SNES_reset_strobe)
    $fell(in_addr) |-> ($past(in_addr, 8) && !$past(in_addr, 9))
  ) else $error("ADDR state did not last 8 cycles");

endmodule

bind sd2snes_main sd2snes_main_asserts i_sd2snes_main_asserts (.*);

// ==== logic/sd2snes_main.sv ====
`timescale 1ns/1ns

module sd2snes_main (
  input  logic        CLK2,
  input  logic        SNES_reset_strobe,
  // SNES bus
  input  logic [23:0] snes_addr_raw,
  input  logic [7:0]  snes_data_raw,
  input  logic        snes_read_raw,
  input  logic        snes_write_raw,
  input  logic        snes_romsel_raw,
  input  logic        snes_cpu_clk_raw,
  output logic [7:0]  snes_data_out,
  output logic        snes_databus_dir,
  output logic [7:0]  snes_data_in,
  output logic        rd_start,
  output logic        rd_end,
  output logic        wr_end,
  output logic        snes_dead,
  // MCU side
  input  logic        mcu_rrq,
  input  logic        mcu_wrq,
  input  logic [23:0] mcu_addr,
  input  logic [7:0]  mcu_dout,
  input  logic [23:0] rom_mask,
  output logic        mcu_rdy,
  output logic [7:0]  mcu_din,
  // PSRAM
  input  logic [15:0] rom_data_in,
  output logic [22:0] rom_addr,
  output logic        rom_bhe,
  output logic        rom_ble,
  output logic        rom_we,
  output logic [15:0] rom_data_out,
  output logic        rom_data_oe
);

  logic [23:0]          snes_addr;
  logic                 snes_read;
  logic                 snes_romsel;
  logic                 cycle_start;
  logic                 cycle_end;
  snes_pkg::arb_state_e state;
  logic [23:0]          acc_addr;

  snes_bus_sync i_snes_bus_sync (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .snes_addr_raw     (snes_addr_raw),
    .snes_data_raw     (snes_data_raw),
    .snes_read_raw     (snes_read_raw),
    .snes_write_raw    (snes_write_raw),
    .snes_romsel_raw   (snes_romsel_raw),
    .snes_cpu_clk_raw  (snes_cpu_clk_raw),
    .snes_addr         (snes_addr),
    .snes_data_in      (snes_data_in),
    .snes_read         (snes_read),
    .snes_romsel       (snes_romsel),
    .rd_start          (rd_start),
    .rd_end            (rd_end),
    .wr_end            (wr_end),
    .cycle_start       (cycle_start),
    .cycle_end         (cycle_end),
    .snes_dead         (snes_dead)
  );

  rom_arbiter i_rom_arbiter (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .mcu_rrq           (mcu_rrq),
    .mcu_wrq           (mcu_wrq),
    .mcu_addr          (mcu_addr),
    .cycle_start       (cycle_start),
    .cycle_end         (cycle_end),
    .snes_dead         (snes_dead),
    .snes_romsel       (snes_romsel),
    .rom_data_in       (rom_data_in),
    .state             (state),
    .acc_addr          (acc_addr),
    .mcu_rdy           (mcu_rdy),
    .mcu_din           (mcu_din)
  );

  rom_port_mux i_rom_port_mux (
    .state             (state),
    .acc_addr          (acc_addr),
    .mcu_dout          (mcu_dout),
    .snes_addr         (snes_addr),
    .snes_read         (snes_read),
    .rom_mask          (rom_mask),
    .rom_data_in       (rom_data_in),
    .rom_addr          (rom_addr),
    .rom_bhe           (rom_bhe),
    .rom_ble           (rom_ble),
    .rom_we            (rom_we),
    .rom_data_out      (rom_data_out),
    .rom_data_oe       (rom_data_oe),
    .snes_data_out     (snes_data_out),
    .snes_databus_dir  (snes_databus_dir)
  );

endmodule

// ==== rom/rom_port_mux.sv ====
`timescale 1ns/1ns

module rom_port_mux (
  input  snes_pkg::arb_state_e          state,
  input  logic [23:0]                   acc_addr,
  input  logic [7:0]                    mcu_dout,
  input  logic [23:0]                   snes_addr,
  input  logic                          snes_read,
  input  logic [23:0]                   rom_mask,
  input  logic [15:0]                   rom_data_in,
  output logic [snes_pkg::rom_addr_w-1:0] rom_addr,
  output logic                          rom_bhe,
  output logic                          rom_ble,
  output logic                          rom_we,
  output logic [15:0]                   rom_data_out,
  output logic                          rom_data_oe,
  output logic [7:0]                    snes_data_out,
  output logic                          snes_databus_dir
);

  logic                         mcu_hit;
  logic                         wr_hit;
  logic [snes_pkg::snes_addr_w-1:0] addr_sel;
  logic                         addr0;

  assign mcu_hit = (state != snes_pkg::arb_idle);
  assign wr_hit  = (state == snes_pkg::arb_mcu_wr_addr) ||
                   (state == snes_pkg::arb_mcu_wr_end);

  // MCU window owns the bus, else the SNES gets its masked ROM address
  assign addr_sel = mcu_hit ? acc_addr : (snes_addr & rom_mask);
  assign addr0    = addr_sel[0];
  assign rom_addr = addr_sel[snes_pkg::snes_addr_w-1:1];

  // byte enables active low, odd byte lives in bits 7:0
  assign rom_bhe = addr0;
  assign rom_ble = ~addr0;

  //////////////////////////////////////////////////////////////////////////
  // PSRAM write path
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    rom_data_out = 16'h0000;
    if (addr0) begin
      rom_data_out[7:0] = mcu_dout;
    end else begin
      rom_data_out[15:8] = mcu_dout;
    end
  end

  assign rom_data_oe = wr_hit;
  assign rom_we      = ~(state == snes_pkg::arb_mcu_wr_addr);  // END state releases we

  //////////////////////////////////////////////////////////////////////////
  // SNES side
  //////////////////////////////////////////////////////////////////////////

  assign snes_databus_dir = ~snes_read;  // 1 drives toward the SNES
  assign snes_data_out    = addr0 ? rom_data_in[7:0] : rom_data_in[15:8];

endmodule

// ==== rom/rom_arbiter.sv ====
`timescale 1ns/1ns

module rom_arbiter (
  input  logic                 CLK2,
  input  logic                 SNES_reset_strobe,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  input  logic [23:0]          mcu_addr,
  input  logic                 cycle_start,
  input  logic                 cycle_end,
  input  logic                 snes_dead,
  input  logic                 snes_romsel,
  input  logic [15:0]          rom_data_in,
  output snes_pkg::arb_state_e state,
  output logic [23:0]          acc_addr,
  output logic                 mcu_rdy,
  output logic [7:0]           mcu_din
);

  logic       rom_hit;
  logic       free_strobe;
  logic       free_slot;
  logic       rd_pend;
  logic       wr_pend;
  logic       acc_done;
  logic [3:0] mem_delay;

  assign rom_hit = ~snes_romsel;  // romsel is active low

  // cpu cycle that does not touch ROM leaves the bus to us
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  assign free_slot = cycle_end | free_strobe;
  assign acc_done  = (state == snes_pkg::arb_mcu_rd_end) ||
                     (state == snes_pkg::arb_mcu_wr_end);

  //////////////////////////////////////////////////////////////////////////
  // MCU request latch
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin  // read wins
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (acc_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq | mcu_wrq) acc_addr <= mcu_addr;
  end

  //////////////////////////////////////////////////////////////////////////
  // slot FSM
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      state     <= snes_pkg::arb_idle;
      mem_delay <= '0;
    end else if (snes_dead & cycle_start) begin
      state <= snes_pkg::arb_idle;  // SNES woke up, pending access restarts
    end else begin
      case (state)
        snes_pkg::arb_idle: begin
          if (free_slot | snes_dead) begin
            if (rd_pend) begin
              state     <= snes_pkg::arb_mcu_rd_addr;
              mem_delay <= 4'(snes_pkg::rom_cycle_len);
            end else if (wr_pend) begin
              state     <= snes_pkg::arb_mcu_wr_addr;
              mem_delay <= 4'(snes_pkg::rom_cycle_len);
            end
          end
        end
        snes_pkg::arb_mcu_rd_addr: begin
          mem_delay <= mem_delay - 1'b1;
          if (mem_delay == '0) state <= snes_pkg::arb_mcu_rd_end;
        end
        snes_pkg::arb_mcu_wr_addr: begin
          mem_delay <= mem_delay - 1'b1;
          if (mem_delay == '0) state <= snes_pkg::arb_mcu_wr_end;
        end
        default: state <= snes_pkg::arb_idle;  // both END states
      endcase
    end
  end

  // last sample of the window is the one the MCU sees
  always_ff @(posedge CLK2) begin
    if (state == snes_pkg::arb_mcu_rd_addr) begin
      mcu_din <= acc_addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];
    end
  end

endmodule

// ==== snes_bus/snes_bus_sync.sv ====
`timescale 1ns/1ns

module snes_bus_sync (
  input  logic        CLK2,
  input  logic        SNES_reset_strobe,
  input  logic [23:0] snes_addr_raw,
  input  logic [7:0]  snes_data_raw,
  input  logic        snes_read_raw,
  input  logic        snes_write_raw,
  input  logic        snes_romsel_raw,
  input  logic        snes_cpu_clk_raw,
  output logic [23:0] snes_addr,
  output logic [7:0]  snes_data_in,
  output logic        snes_read,
  output logic        snes_romsel,
  output logic        rd_start,
  output logic        rd_end,
  output logic        wr_end,
  output logic        cycle_start,
  output logic        cycle_end,
  output logic        snes_dead
);

  logic [snes_pkg::strobe_hist_len-1:0] read_hist;
  logic [snes_pkg::strobe_hist_len-1:0] write_hist;
  logic [snes_pkg::strobe_hist_len-1:0] romsel_hist;
  logic [snes_pkg::strobe_hist_len-1:0] cpu_clk_hist;

  logic [snes_pkg::snes_addr_w-1:0] addr_hist [0:5];
  logic [7:0]                       data_hist [0:3];

  logic [$clog2(snes_pkg::snes_dead_timeout):0] dead_cnt;

  //////////////////////////////////////////////////////////////////////////
  // strobe history, newest sample in bit 0
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      read_hist    <= '1;  // strobes idle high
      write_hist   <= '1;
      romsel_hist  <= '1;
      cpu_clk_hist <= '0;
    end else begin
      read_hist    <= {read_hist[snes_pkg::strobe_hist_len-2:0], snes_read_raw};
      write_hist   <= {write_hist[snes_pkg::strobe_hist_len-2:0], snes_write_raw};
      romsel_hist  <= {romsel_hist[snes_pkg::strobe_hist_len-2:0], snes_romsel_raw};
      cpu_clk_hist <= {cpu_clk_hist[snes_pkg::strobe_hist_len-2:0], snes_cpu_clk_raw};
    end
  end

  // edge patterns need five stable samples before the change
  assign rd_start    = (read_hist[6:1] == 6'b111110);
  assign rd_end      = (read_hist[6:1] == 6'b000001);
  assign wr_end      = (write_hist[6:1] == 6'b000001);
  assign cycle_start = (cpu_clk_hist[6:1] == 6'b000001);
  assign cycle_end   = (cpu_clk_hist[6:1] == 6'b111110);

  assign snes_read   = read_hist[2] & read_hist[1];
  assign snes_romsel = romsel_hist[5] & romsel_hist[4];  // late, matches address

  //////////////////////////////////////////////////////////////////////////
  // address and data sampling
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    addr_hist[0] <= snes_addr_raw;
    for (int i = 1; i < 6; i++) begin
      addr_hist[i] <= addr_hist[i-1];
    end
    data_hist[0] <= snes_data_raw;
    for (int i = 1; i < 4; i++) begin
      data_hist[i] <= data_hist[i-1];
    end
  end

  // and of two copies masks single-cycle glitches toward 0
  assign snes_addr    = addr_hist[5] & addr_hist[4];
  assign snes_data_in = data_hist[3] & data_hist[2];

  //////////////////////////////////////////////////////////////////////////
  // dead detection
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      dead_cnt <= '0;
    end else if (cpu_clk_hist[1]) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= snes_pkg::snes_dead_timeout) begin
      dead_cnt <= dead_cnt + 1'b1;  // saturates just past timeout
    end
  end

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      snes_dead <= 1'b1;  // dead until the cpu clock shows up
    end else if (cpu_clk_hist[1]) begin
      snes_dead <= 1'b0;
    end else if (dead_cnt > snes_pkg::snes_dead_timeout) begin
      snes_dead <= 1'b1;
    end
  end

endmodule

// ==== common/snes_pkg.sv ====
package snes_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int snes_addr_w = 24;  // SNES A-bus plus bank
  localparam int rom_addr_w = 23;   // PSRAM word address

  ////////////////////////////////////////////////////////////////////////////
  // timing
  ////////////////////////////////////////////////////////////////////////////

  // countdown start of the memory window, 8 cycles in the ADDR state
  localparam int rom_cycle_len = 7;

  // CLK2 cycles of CPU clock low before the SNES counts as dead (about 1 ms)
  localparam int snes_dead_timeout = 96000;

  localparam int strobe_hist_len = 8;  // strobe shift register depth

  ////////////////////////////////////////////////////////////////////////////
  // arbiter states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    arb_idle,
    arb_mcu_rd_addr,  // read window, data captured every cycle
    arb_mcu_rd_end,
    arb_mcu_wr_addr,  // write window, we low
    arb_mcu_wr_end
  } arb_state_e;

endpackage
